// ==== src/fpu_pkg.sv ====
package fpu_pkg;

	// binary32 format
	localparam int FPU_EXP_BIAS = 127;
	localparam int FPU_EXP_W = 10;
	localparam int FPU_MANT_W = 24;

	// smallest normal exponent, also the exponent of every denormal
	localparam logic signed [FPU_EXP_W-1:0] FPU_EXP_MIN = FPU_EXP_W'(-126);

	localparam logic [31:0] FPU_QNAN = 32'hffc00000;
	localparam logic [7:0] FPU_INF_EXP = 8'hff;

	// code 2'd3 is not named and behaves as an add
	typedef enum logic [1:0] {
		FPU_OP_MUL = 2'd0,
		FPU_OP_ADD = 2'd1,
		FPU_OP_SUB = 2'd2
	} fpu_op_t;

	typedef enum logic [1:0] {
		FPU_CLASS_ZERO = 2'd0,
		FPU_CLASS_FINITE = 2'd1,
		FPU_CLASS_INF = 2'd2,
		FPU_CLASS_NAN = 2'd3
	} fpu_class_t;

endpackage

// ==== src/fpu_classify.sv ====
`timescale 1ns/100ps

module fpu_classify import fpu_pkg::*; (
	input logic i_clock,
	input logic i_load,
	input logic i_step,
	input logic [31:0] i_operand,

	output logic o_sign,
	output logic signed [FPU_EXP_W-1:0] o_exp,
	output logic [FPU_MANT_W-1:0] o_mant,
	output fpu_class_t o_class,
	output logic o_normalized
);

	logic [7:0] exp_field;
	logic [22:0] frac;
	logic signed [FPU_EXP_W-1:0] exp_unbiased;

	assign exp_field = i_operand[30:23];
	assign frac = i_operand[22:0];
	assign exp_unbiased = $signed({2'b00, exp_field}) - FPU_EXP_W'(FPU_EXP_BIAS);

	always_ff @(posedge i_clock) begin
		if (i_load) begin
			o_sign <= i_operand[31];
			if (exp_field == FPU_INF_EXP) begin
				o_class <= (|frac) ? FPU_CLASS_NAN : FPU_CLASS_INF;
				o_exp <= exp_unbiased;
				o_mant <= {1'b1, frac};
			end else if (exp_field == 8'd0) begin
				// denormals sit at the minimum exponent with no hidden bit
				o_class <= (|frac) ? FPU_CLASS_FINITE : FPU_CLASS_ZERO;
				o_exp <= FPU_EXP_MIN;
				o_mant <= {1'b0, frac};
			end else begin
				o_class <= FPU_CLASS_FINITE;
				o_exp <= exp_unbiased;
				o_mant <= {1'b1, frac};
			end
		end else if (i_step && !o_normalized) begin
			// one bit per cycle until the hidden bit position is set
			o_mant <= {o_mant[FPU_MANT_W-2:0], 1'b0};
			o_exp <= o_exp - FPU_EXP_W'(1);
		end
	end

	assign o_normalized = (o_class != FPU_CLASS_FINITE) || o_mant[FPU_MANT_W-1];

endmodule

// ==== src/fpu_mul_core.sv ====
`timescale 1ns/100ps

module fpu_mul_core import fpu_pkg::*; (
	input logic i_clock,
	input logic i_start,
	input logic i_a_sign,
	input logic signed [FPU_EXP_W-1:0] i_a_exp,
	input logic [FPU_MANT_W-1:0] i_a_mant,
	input logic i_b_sign,
	input logic signed [FPU_EXP_W-1:0] i_b_exp,
	input logic [FPU_MANT_W-1:0] i_b_mant,

	output logic o_sign,
	output logic signed [FPU_EXP_W-1:0] o_exp,
	output logic [23:0] o_mant,
	output logic o_guard,
	output logic o_round,
	output logic o_sticky,
	output logic o_done
);

	logic [2*FPU_MANT_W-1:0] product;
	logic product_sign;
	logic signed [FPU_EXP_W-1:0] product_exp;
	logic stage1;

	always_ff @(posedge i_clock) begin
		stage1 <= i_start;
		o_done <= stage1;
		if (i_start) begin
			product <= (2*FPU_MANT_W)'(i_a_mant) * (2*FPU_MANT_W)'(i_b_mant);
			product_sign <= i_a_sign ^ i_b_sign;
			// plus one because the product's binary point sits below bit 46
			product_exp <= i_a_exp + i_b_exp + FPU_EXP_W'(1);
		end
		if (stage1) begin
			o_sign <= product_sign;
			o_exp <= product_exp;
			o_mant <= product[47:24];
			o_guard <= product[23];
			o_round <= product[22];
			o_sticky <= |product[21:0];
		end
	end

endmodule

// ==== src/fpu_add_core.sv ====
`timescale 1ns/100ps

module fpu_add_core import fpu_pkg::*; (
	input logic i_clock,
	input logic i_start,
	input logic i_subtract,
	input logic i_a_sign,
	input logic signed [FPU_EXP_W-1:0] i_a_exp,
	input logic [FPU_MANT_W-1:0] i_a_mant,
	input logic i_b_sign,
	input logic signed [FPU_EXP_W-1:0] i_b_exp,
	input logic [FPU_MANT_W-1:0] i_b_mant,

	output logic o_sign,
	output logic signed [FPU_EXP_W-1:0] o_exp,
	output logic [23:0] o_mant,
	output logic o_guard,
	output logic o_round,
	output logic o_sticky,
	output logic o_zero,
	output logic o_done
);

	logic b_eff_sign;
	logic swap;
	logic signed [FPU_EXP_W-1:0] exp_diff;
	logic [4:0] shamt;
	logic [FPU_MANT_W-1:0] small_in;
	logic [2*FPU_MANT_W-1:0] shifted;

	logic stage1;
	logic big_sign, small_sign;
	logic signed [FPU_EXP_W-1:0] big_exp;
	logic [FPU_MANT_W-1:0] big_mant, small_mant;
	logic small_guard, small_round, small_sticky;

	logic [FPU_MANT_W+2:0] x_mag, y_mag, diff_mag;
	logic [FPU_MANT_W+3:0] sum;
	logic y_larger;

	assign b_eff_sign = i_b_sign ^ i_subtract;

	// a zero operand always takes the small side so it never forces a shift
	assign swap = (i_a_mant == '0) || ((i_b_mant != '0) && (i_b_exp > i_a_exp));
	assign exp_diff = swap ? (i_b_exp - i_a_exp) : (i_a_exp - i_b_exp);
	assign small_in = swap ? i_a_mant : i_b_mant;
	assign shamt = ((small_in == '0) || (exp_diff > 26)) ? 5'd26 : exp_diff[4:0];
	assign shifted = {small_in, {FPU_MANT_W{1'b0}}} >> shamt;

	assign x_mag = {big_mant, 3'b000};
	assign y_mag = {small_mant, small_guard, small_round, small_sticky};
	assign sum = {1'b0, x_mag} + {1'b0, y_mag};
	assign y_larger = y_mag > x_mag;
	assign diff_mag = y_larger ? (y_mag - x_mag) : (x_mag - y_mag);

	always_ff @(posedge i_clock) begin
		stage1 <= i_start;
		o_done <= stage1;
		if (i_start) begin
			big_sign <= swap ? b_eff_sign : i_a_sign;
			small_sign <= swap ? i_a_sign : b_eff_sign;
			big_exp <= swap ? i_b_exp : i_a_exp;
			big_mant <= swap ? i_b_mant : i_a_mant;
			small_mant <= shifted[47:24];
			small_guard <= shifted[23];
			small_round <= shifted[22];
			small_sticky <= |shifted[21:0];
		end
		if (stage1) begin
			if (big_sign == small_sign) begin
				o_zero <= (sum == '0);
				o_sign <= big_sign;
				if (sum[FPU_MANT_W+3]) begin
					// carry out, shift right once into guard
					o_mant <= sum[27:4];
					o_guard <= sum[3];
					o_round <= sum[2];
					o_sticky <= |sum[1:0];
					o_exp <= big_exp + FPU_EXP_W'(1);
				end else begin
					o_mant <= sum[26:3];
					o_guard <= sum[2];
					o_round <= sum[1];
					o_sticky <= sum[0];
					o_exp <= big_exp;
				end
			end else begin
				// exact cancellation gives +0
				o_zero <= (diff_mag == '0);
				o_sign <= (diff_mag == '0) ? 1'b0 : (y_larger ? small_sign : big_sign);
				o_mant <= diff_mag[26:3];
				o_guard <= diff_mag[2];
				o_round <= diff_mag[1];
				o_sticky <= diff_mag[0];
				o_exp <= big_exp;
			end
		end
	end

endmodule

// ==== src/fpu_round_pack.sv ====
`timescale 1ns/100ps

module fpu_round_pack import fpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_start,
	input logic i_sel_add,

	input logic i_mul_sign,
	input logic signed [FPU_EXP_W-1:0] i_mul_exp,
	input logic [23:0] i_mul_mant,
	input logic i_mul_guard,
	input logic i_mul_round,
	input logic i_mul_sticky,

	input logic i_add_sign,
	input logic signed [FPU_EXP_W-1:0] i_add_exp,
	input logic [23:0] i_add_mant,
	input logic i_add_guard,
	input logic i_add_round,
	input logic i_add_sticky,
	input logic i_add_zero,

	output logic [31:0] o_result,
	output logic o_done
);

	typedef enum logic [2:0] {
		IDLE,
		NORM_LEFT,
		NORM_RIGHT,
		ROUND,
		PACK
	} state_t;

	state_t state;
	logic done;
	logic [31:0] result;

	logic z_sign, z_zero;
	logic signed [FPU_EXP_W-1:0] z_exp;
	logic [FPU_MANT_W-1:0] z_mant;
	logic guard, round_bit, sticky;
	logic [FPU_EXP_W-1:0] exp_biased;

	assign exp_biased = z_exp + FPU_EXP_W'(FPU_EXP_BIAS);

	always_ff @(posedge i_clock) begin
		done <= 1'b0;
		case (state)
			IDLE: begin
				if (i_start) begin
					z_sign <= i_sel_add ? i_add_sign : i_mul_sign;
					z_exp <= i_sel_add ? i_add_exp : i_mul_exp;
					z_mant <= i_sel_add ? i_add_mant : i_mul_mant;
					guard <= i_sel_add ? i_add_guard : i_mul_guard;
					round_bit <= i_sel_add ? i_add_round : i_mul_round;
					sticky <= i_sel_add ? i_add_sticky : i_mul_sticky;
					z_zero <= i_sel_add && i_add_zero;
					state <= NORM_LEFT;
				end
			end

			NORM_LEFT: begin
				if (z_zero) begin
					state <= PACK;
				end else if (!z_mant[FPU_MANT_W-1]) begin
					z_mant <= {z_mant[FPU_MANT_W-2:0], guard};
					guard <= round_bit;
					round_bit <= 1'b0;
					z_exp <= z_exp - FPU_EXP_W'(1);
				end else begin
					state <= NORM_RIGHT;
				end
			end

			NORM_RIGHT: begin
				// denormal result, shift down to the minimum exponent
				if (z_exp < FPU_EXP_MIN) begin
					z_mant <= {1'b0, z_mant[FPU_MANT_W-1:1]};
					guard <= z_mant[0];
					round_bit <= guard;
					sticky <= sticky | round_bit;
					z_exp <= z_exp + FPU_EXP_W'(1);
				end else begin
					state <= ROUND;
				end
			end

			ROUND: begin
				if (guard && (round_bit || sticky || z_mant[0])) begin
					if (&z_mant) begin
						z_mant <= {1'b1, {(FPU_MANT_W-1){1'b0}}};
						z_exp <= z_exp + FPU_EXP_W'(1);
					end else begin
						z_mant <= z_mant + FPU_MANT_W'(1);
					end
				end
				state <= PACK;
			end

			PACK: begin
				if (z_zero) begin
					result <= {z_sign, 31'd0};
				end else if (z_exp > FPU_EXP_W'(FPU_EXP_BIAS)) begin
					result <= {z_sign, FPU_INF_EXP, 23'd0};
				end else if (!z_mant[FPU_MANT_W-1]) begin
					// no hidden bit left, so this is a denormal or zero
					result <= {z_sign, 8'd0, z_mant[22:0]};
				end else begin
					result <= {z_sign, exp_biased[7:0], z_mant[22:0]};
				end
				done <= 1'b1;
				state <= IDLE;
			end

			default: begin
				state <= IDLE;
			end
		endcase

		if (i_reset) begin
			done <= 1'b0;
			state <= IDLE;
		end
	end

	assign o_result = result;
	assign o_done = done;

endmodule

// ==== src/fpu_control.sv ====
`timescale 1ns/100ps

module fpu_control import fpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input fpu_op_t i_op,

	input logic i_a_sign,
	input fpu_class_t i_a_class,
	input logic i_a_normalized,
	input logic i_b_sign,
	input fpu_class_t i_b_class,
	input logic i_b_normalized,

	input logic i_mul_done,
	input logic i_add_done,
	input logic i_round_done,
	input logic [31:0] i_round_result,

	output logic o_load,
	output logic o_a_step,
	output logic o_b_step,
	output logic o_mul_start,
	output logic o_add_start,
	output logic o_subtract,
	output logic o_sel_add,
	output logic o_round_start,
	output logic o_ready,
	output logic [31:0] o_result
);

	typedef enum logic [2:0] {
		IDLE,
		CLASSIFY,
		EXECUTE,
		ROUND,
		DONE
	} state_t;

	state_t state;
	logic ready;
	logic [31:0] result;

	logic is_mul, is_sub, b_eff_sign, mul_sign;
	logic a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
	logic operands_ready, core_done;
	logic special;
	logic [31:0] special_result;

	assign is_mul = (i_op == FPU_OP_MUL);
	assign is_sub = (i_op == FPU_OP_SUB);
	assign b_eff_sign = i_b_sign ^ is_sub;
	assign mul_sign = i_a_sign ^ i_b_sign;

	assign a_nan = (i_a_class == FPU_CLASS_NAN);
	assign b_nan = (i_b_class == FPU_CLASS_NAN);
	assign a_inf = (i_a_class == FPU_CLASS_INF);
	assign b_inf = (i_b_class == FPU_CLASS_INF);
	assign a_zero = (i_a_class == FPU_CLASS_ZERO);
	assign b_zero = (i_b_class == FPU_CLASS_ZERO);

	assign operands_ready = (state == CLASSIFY) && i_a_normalized && i_b_normalized;
	assign core_done = is_mul ? i_mul_done : i_add_done;

	// zeros in an add are left to the adder for the sign rules
	always_comb begin
		special = 1'b1;
		special_result = FPU_QNAN;
		if (a_nan || b_nan) begin
			special_result = FPU_QNAN;
		end else if (is_mul) begin
			if ((a_inf && b_zero) || (b_inf && a_zero)) begin
				special_result = FPU_QNAN;
			end else if (a_inf || b_inf) begin
				special_result = {mul_sign, FPU_INF_EXP, 23'd0};
			end else if (a_zero || b_zero) begin
				special_result = {mul_sign, 31'd0};
			end else begin
				special = 1'b0;
			end
		end else if (a_inf && b_inf) begin
			// opposite infinities cancel
			if (i_a_sign != b_eff_sign) begin
				special_result = FPU_QNAN;
			end else begin
				special_result = {i_a_sign, FPU_INF_EXP, 23'd0};
			end
		end else if (a_inf) begin
			special_result = {i_a_sign, FPU_INF_EXP, 23'd0};
		end else if (b_inf) begin
			special_result = {b_eff_sign, FPU_INF_EXP, 23'd0};
		end else begin
			special = 1'b0;
		end
	end

	assign o_load = (state == IDLE) && i_request;
	assign o_a_step = (state == CLASSIFY) && !i_a_normalized;
	assign o_b_step = (state == CLASSIFY) && !i_b_normalized;
	assign o_mul_start = operands_ready && !special && is_mul;
	assign o_add_start = operands_ready && !special && !is_mul;
	assign o_subtract = is_sub;
	assign o_sel_add = !is_mul;
	assign o_round_start = (state == EXECUTE) && core_done;

	always_ff @(posedge i_clock) begin
		case (state)
			IDLE: begin
				ready <= 1'b0;
				if (i_request) begin
					state <= CLASSIFY;
				end
			end

			CLASSIFY: begin
				if (operands_ready) begin
					if (special) begin
						result <= special_result;
						ready <= 1'b1;
						state <= DONE;
					end else begin
						state <= EXECUTE;
					end
				end
			end

			EXECUTE: begin
				if (core_done) begin
					state <= ROUND;
				end
			end

			ROUND: begin
				if (i_round_done) begin
					result <= i_round_result;
					ready <= 1'b1;
					state <= DONE;
				end
			end

			DONE: begin
				// result is held until the CPU lets go of the request
				if (!i_request) begin
					ready <= 1'b0;
					state <= IDLE;
				end
			end

			default: begin
				state <= IDLE;
			end
		endcase

		if (i_reset) begin
			ready <= 1'b0;
			state <= IDLE;
		end
	end

	assign o_ready = ready;
	assign o_result = result;

endmodule

// ==== src/fpu_top.sv ====
`timescale 1ns/100ps

module fpu_top import fpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input fpu_op_t i_op,
	input logic [31:0] i_op1,
	input logic [31:0] i_op2,

	output logic o_ready,
	output logic [31:0] o_result
);

	logic load, a_step, b_step;
	logic mul_start, add_start, subtract, sel_add, round_start;
	logic mul_done, add_done, round_done;
	logic [31:0] round_result;

	logic a_sign, b_sign;
	logic signed [FPU_EXP_W-1:0] a_exp, b_exp;
	logic [FPU_MANT_W-1:0] a_mant, b_mant;
	fpu_class_t a_class, b_class;
	logic a_normalized, b_normalized;

	logic mul_sign, mul_guard, mul_round, mul_sticky;
	logic signed [FPU_EXP_W-1:0] mul_exp;
	logic [23:0] mul_mant;

	logic add_sign, add_guard, add_round, add_sticky, add_zero;
	logic signed [FPU_EXP_W-1:0] add_exp;
	logic [23:0] add_mant;

	fpu_control u_control (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_op(i_op),
		.i_a_sign(a_sign),
		.i_a_class(a_class),
		.i_a_normalized(a_normalized),
		.i_b_sign(b_sign),
		.i_b_class(b_class),
		.i_b_normalized(b_normalized),
		.i_mul_done(mul_done),
		.i_add_done(add_done),
		.i_round_done(round_done),
		.i_round_result(round_result),
		.o_load(load),
		.o_a_step(a_step),
		.o_b_step(b_step),
		.o_mul_start(mul_start),
		.o_add_start(add_start),
		.o_subtract(subtract),
		.o_sel_add(sel_add),
		.o_round_start(round_start),
		.o_ready(o_ready),
		.o_result(o_result)
	);

	fpu_classify u_classify_a (
		.i_clock(i_clock),
		.i_load(load),
		.i_step(a_step),
		.i_operand(i_op1),
		.o_sign(a_sign),
		.o_exp(a_exp),
		.o_mant(a_mant),
		.o_class(a_class),
		.o_normalized(a_normalized)
	);

	fpu_classify u_classify_b (
		.i_clock(i_clock),
		.i_load(load),
		.i_step(b_step),
		.i_operand(i_op2),
		.o_sign(b_sign),
		.o_exp(b_exp),
		.o_mant(b_mant),
		.o_class(b_class),
		.o_normalized(b_normalized)
	);

	fpu_mul_core u_mul_core (
		.i_clock(i_clock),
		.i_start(mul_start),
		.i_a_sign(a_sign),
		.i_a_exp(a_exp),
		.i_a_mant(a_mant),
		.i_b_sign(b_sign),
		.i_b_exp(b_exp),
		.i_b_mant(b_mant),
		.o_sign(mul_sign),
		.o_exp(mul_exp),
		.o_mant(mul_mant),
		.o_guard(mul_guard),
		.o_round(mul_round),
		.o_sticky(mul_sticky),
		.o_done(mul_done)
	);

	fpu_add_core u_add_core (
		.i_clock(i_clock),
		.i_start(add_start),
		.i_subtract(subtract),
		.i_a_sign(a_sign),
		.i_a_exp(a_exp),
		.i_a_mant(a_mant),
		.i_b_sign(b_sign),
		.i_b_exp(b_exp),
		.i_b_mant(b_mant),
		.o_sign(add_sign),
		.o_exp(add_exp),
		.o_mant(add_mant),
		.o_guard(add_guard),
		.o_round(add_round),
		.o_sticky(add_sticky),
		.o_zero(add_zero),
		.o_done(add_done)
	);

	fpu_round_pack u_round_pack (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_start(round_start),
		.i_sel_add(sel_add),
		.i_mul_sign(mul_sign),
		.i_mul_exp(mul_exp),
		.i_mul_mant(mul_mant),
		.i_mul_guard(mul_guard),
		.i_mul_round(mul_round),
		.i_mul_sticky(mul_sticky),
		.i_add_sign(add_sign),
		.i_add_exp(add_exp),
		.i_add_mant(add_mant),
		.i_add_guard(add_guard),
		.i_add_round(add_round),
		.i_add_sticky(add_sticky),
		.i_add_zero(add_zero),
		.o_result(round_result),
		.o_done(round_done)
	);

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
	output logic o_clock,
	output logic o_reset
);

	// 100 ns period
	initial begin
		o_clock = 1'b0;
		forever begin
			#50 o_clock = ~o_clock;
		end
	end

	// held for 4 rising edges, released on a falling edge
	initial begin
		o_reset = 1'b1;
		repeat (4) @(posedge o_clock);
		@(negedge o_clock);
		o_reset = 1'b0;
	end

endmodule

// ==== dv/tb_fpu.sv ====
`timescale 1ns/100ps

module tb_fpu import fpu_pkg::*; ();

	localparam int CLOCK_PERIOD_NS = 100;
	localparam int RESET_CYCLES = 4;
	localparam int CYCLES_PER_ROW = 200;
	localparam int NUM_ROWS = 33;
	localparam int WATCHDOG_NS = (NUM_ROWS * CYCLES_PER_ROW + RESET_CYCLES) * CLOCK_PERIOD_NS;

	// each row is {op, operand 1, operand 2, expected result}
	localparam logic [97:0] VECTORS [NUM_ROWS] = '{
		// normal multiplies both exact and rounded
		{FPU_OP_MUL, 32'h40400000, 32'h3fc00000, 32'h40900000},
		{FPU_OP_MUL, 32'h3f800001, 32'h3f800001, 32'h3f800002},
		{FPU_OP_MUL, 32'h3fc00001, 32'h3fc00000, 32'h40100001},
		// ties where an odd lsb goes up and an even lsb stays
		{FPU_OP_MUL, 32'h3f800001, 32'h3fc00000, 32'h3fc00002},
		{FPU_OP_MUL, 32'h3f800003, 32'h3fc00000, 32'h3fc00004},
		// add with carry and alignment with sticky
		{FPU_OP_ADD, 32'h3fc00000, 32'h3fc00000, 32'h40400000},
		{FPU_OP_ADD, 32'h3f800000, 32'h3f800001, 32'h40000000},
		{FPU_OP_ADD, 32'h3f800000, 32'h33820000, 32'h3f800001},
		{FPU_OP_SUB, 32'h3f800000, 32'h33000000, 32'h3f800000},
		{FPU_OP_SUB, 32'h3f800000, 32'h40400000, 32'hc0000000},
		// cancellation and signed zeros
		{FPU_OP_SUB, 32'h3fc00000, 32'h3fc00000, 32'h00000000},
		{FPU_OP_ADD, 32'h3fc00000, 32'hbfc00000, 32'h00000000},
		{FPU_OP_ADD, 32'h80000000, 32'h80000000, 32'h80000000},
		{FPU_OP_SUB, 32'h80000000, 32'h00000000, 32'h80000000},
		// unnamed code acts as add
		{2'd3, 32'h3f800000, 32'h3f800000, 32'h40000000},
		// NaN, infinity and zero handling
		{FPU_OP_MUL, 32'h7fc00000, 32'h3f800000, 32'hffc00000},
		{FPU_OP_ADD, 32'h3f800000, 32'h7f800001, 32'hffc00000},
		{FPU_OP_MUL, 32'h7f800000, 32'h00000000, 32'hffc00000},
		{FPU_OP_SUB, 32'h7f800000, 32'h7f800000, 32'hffc00000},
		{FPU_OP_MUL, 32'h7f800000, 32'hc0000000, 32'hff800000},
		{FPU_OP_ADD, 32'hff800000, 32'h3f800000, 32'hff800000},
		{FPU_OP_MUL, 32'h80000000, 32'h40400000, 32'h80000000},
		// denormal operands and results
		{FPU_OP_MUL, 32'h00000001, 32'h40000000, 32'h00000002},
		{FPU_OP_MUL, 32'h00400000, 32'h40800000, 32'h01000000},
		{FPU_OP_MUL, 32'h00000003, 32'h3f000000, 32'h00000002},
		{FPU_OP_MUL, 32'h00000001, 32'hbe800000, 32'h80000000},
		{FPU_OP_MUL, 32'h1cf00000, 32'h18c00000, 32'h00000006},
		{FPU_OP_ADD, 32'h00000001, 32'h00000001, 32'h00000002},
		{FPU_OP_SUB, 32'h00800000, 32'h00000001, 32'h007fffff},
		// overflow where the last one overflows only by rounding
		{FPU_OP_MUL, 32'h7f000000, 32'h40000000, 32'h7f800000},
		{FPU_OP_MUL, 32'h7f7fffff, 32'hc0000000, 32'hff800000},
		{FPU_OP_SUB, 32'hff7fffff, 32'h7f7fffff, 32'hff800000},
		{FPU_OP_ADD, 32'h7f7fffff, 32'h73000000, 32'h7f800000}
	};

	logic clock;
	logic reset;
	logic request;
	fpu_op_t op;
	logic [31:0] op1;
	logic [31:0] op2;
	logic ready;
	logic [31:0] result;

	integer seed = 32'h715a;
	int row_index;

	tb_clock_gen u_clock_gen (
		.o_clock(clock),
		.o_reset(reset)
	);

	fpu_top i_dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_op(op),
		.i_op1(op1),
		.i_op2(op2),
		.o_ready(ready),
		.o_result(result)
	);

	task automatic stop_on_failure();
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH %s in row %0d: got 0x%08h, expected 0x%08h",
				name, row_index, actual, expected);
			stop_on_failure();
		end
	endtask

	// one full request/ready transaction driven and sampled on falling edges
	task automatic apply_row(input logic [97:0] row);
		logic [31:0] expected;
		int hold_cycles;
		int idle_cycles;

		expected = row[31:0];
		hold_cycles = $unsigned($random(seed)) % 4;
		idle_cycles = $unsigned($random(seed)) % 3;

		op = fpu_op_t'(row[97:96]);
		op1 = row[95:64];
		op2 = row[63:32];
		request = 1'b1;

		@(negedge clock);
		while (!ready) begin
			@(negedge clock);
		end
		check_value("o_result", result, expected);

		// result must hold while the request is held
		repeat (hold_cycles) begin
			@(negedge clock);
			check_value("o_ready", 32'(ready), 32'd1);
			check_value("o_result", result, expected);
		end

		request = 1'b0;
		@(negedge clock);
		check_value("o_ready", 32'(ready), 32'd0);

		repeat (idle_cycles) begin
			@(negedge clock);
		end
	endtask

	initial begin
		request = 1'b0;
		op = FPU_OP_MUL;
		op1 = '0;
		op2 = '0;
		row_index = -1;

		// reset changes on a falling edge, so look at it on rising edges
		@(posedge clock);
		while (reset) begin
			@(posedge clock);
		end
		@(negedge clock);
		check_value("o_ready", 32'(ready), 32'd0);

		for (row_index = 0; row_index < NUM_ROWS; row_index++) begin
			apply_row(VECTORS[row_index]);
		end

		$display("sim passed");
		$finish;
	end

	// fires only if a transaction hangs
	initial begin
		#(WATCHDOG_NS);
		$display("TIMEOUT: o_ready never came for row %0d within %0d ns",
			row_index, WATCHDOG_NS);
		stop_on_failure();
	end

endmodule

// ==== sim.f ====
src/fpu_pkg.sv
src/fpu_classify.sv
src/fpu_mul_core.sv
src/fpu_add_core.sv
src/fpu_round_pack.sv
src/fpu_control.sv
src/fpu_top.sv
dv/tb_clock_gen.sv
dv/tb_fpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the FPU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module tb_fpu \
	-f sim.f -Mdir obj_dir -o tb_fpu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_fpu_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
	echo "test run ok"
	exit 0
fi

echo "test run failed, see $LOG"
exit 1
